// ==== files.f ====
+incdir+hw
+incdir+tb
hw/tl_pkg.sv
hw/tl_rr_arbiter.sv
hw/tl_resp_mux.sv
hw/tl_socket_1n.sv
hw/tl_ram_device.sv
hw/tl_xbar_top.sv
tb/tb_top.sv

// ==== hw/tl_cfg.svh ====
`ifndef TL_CFG_SVH
`define TL_CFG_SVH

// Link widths
`define TL_ADDR_W     16
`define TL_DATA_W     64
`define TL_SIZE_W     3
`define TL_SOURCE_W   2

// Largest message is 32 bytes, four beats of 8 bytes
`define TL_MAX_SIZE   5

// Device links and address routing table
`define TL_NUM_LINKS  2
`define TL_NUM_RANGES 1
`define TL_RANGE_BASE 16'h1000
`define TL_RANGE_MASK 16'h0FFF
`define TL_RANGE_LINK 1

`define TL_RAM_WORDS  64

`endif

// ==== hw/tl_pkg.sv ====
`include "tl_cfg.svh"

package tl_pkg;

  // Sizes up to this one fit in a single beat
  localparam int unsigned tl_non_burst_size = 3;

  // Width of a beat count, beats minus one
  localparam int unsigned tl_burst_w = `TL_MAX_SIZE - tl_non_burst_size;

  typedef enum logic [2:0] {
    tl_put_full_data = 3'h0,
    tl_get           = 3'h4
  } tl_a_op_e;

  // Bit 0 set means the response carries data
  typedef enum logic [2:0] {
    tl_access_ack      = 3'h0,
    tl_access_ack_data = 3'h1
  } tl_d_op_e;

  // Number of beats minus one for a message of the given size
  function automatic logic [tl_burst_w-1:0] tl_burst_len(
    input logic [`TL_SIZE_W-1:0] size
  );
    if (size <= tl_non_burst_size) begin
      return '0;
    end else begin
      return tl_burst_w'((1 << (size - tl_non_burst_size)) - 1);
    end
  endfunction

endpackage

// ==== hw/tl_ram_device.sv ====
`timescale 1ns/1ps

module tl_ram_device import tl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      a_valid,
  output logic                      a_ready,
  input  tl_a_op_e                  a_opcode,
  input  logic [`TL_SIZE_W-1:0]     a_size,
  input  logic [`TL_SOURCE_W-1:0]   a_source,
  input  logic [`TL_ADDR_W-1:0]     a_address,
  input  logic [`TL_DATA_W/8-1:0]   a_mask,
  input  logic [`TL_DATA_W-1:0]     a_data,

  output logic                      d_valid,
  input  logic                      d_ready,
  output tl_d_op_e                  d_opcode,
  output logic [`TL_SIZE_W-1:0]     d_size,
  output logic [`TL_SOURCE_W-1:0]   d_source,
  output logic                      d_denied,
  output logic [`TL_DATA_W-1:0]     d_data
);

  localparam int unsigned idx_lsb = $clog2(`TL_DATA_W / 8);
  localparam int unsigned idx_w   = $clog2(`TL_RAM_WORDS);

  logic [`TL_DATA_W-1:0] mem_q [`TL_RAM_WORDS];

  logic                  busy_q;
  logic [idx_w-1:0]      ptr_q;
  logic [tl_burst_w-1:0] cnt_q;
  logic [idx_w-1:0]      a_idx;
  logic                  accept;
  logic                  is_get;
  logic                  put_ok;

  assign a_ready = !busy_q;
  assign d_valid = busy_q;
  assign accept  = a_valid && a_ready;
  assign a_idx   = a_address[idx_lsb +: idx_w];
  assign is_get  = (a_opcode == tl_get);
  // Puts wider than one beat are refused
  assign put_ok  = !is_get && (a_size <= tl_non_burst_size);

  assign d_data  = mem_q[ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      ptr_q  <= '0;
      cnt_q  <= '0;
      for (int w = 0; w < `TL_RAM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (accept) begin
      busy_q <= 1'b1;
      ptr_q  <= a_idx;
      cnt_q  <= is_get ? tl_burst_len(a_size) : '0;
      if (put_ok) begin
        for (int b = 0; b < `TL_DATA_W / 8; b++) begin
          if (a_mask[b]) begin
            mem_q[a_idx][8*b +: 8] <= a_data[8*b +: 8];
          end
        end
      end
    end else if (d_valid && d_ready) begin
      // Step to the next word, wrapping at the end of the array
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // Response header, captured once per request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_opcode <= is_get ? tl_access_ack_data : tl_access_ack;
      d_size   <= a_size;
      d_source <= a_source;
      d_denied <= !is_get && !put_ok;
    end
  end

  a_one_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_valid && a_ready |=> d_valid && !a_ready);

endmodule

// ==== hw/tl_resp_mux.sv ====
`timescale 1ns/1ps

module tl_resp_mux import tl_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,

  input  logic     [`TL_NUM_LINKS-1:0]                 dev_d_valid,
  output logic     [`TL_NUM_LINKS-1:0]                 dev_d_ready,
  input  tl_d_op_e [`TL_NUM_LINKS-1:0]                 dev_d_opcode,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_SIZE_W-1:0]   dev_d_size,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_SOURCE_W-1:0] dev_d_source,
  input  logic     [`TL_NUM_LINKS-1:0]                 dev_d_denied,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_DATA_W-1:0]   dev_d_data,

  output logic                                         d_valid,
  input  logic                                         d_ready,
  output tl_d_op_e                                     d_opcode,
  output logic     [`TL_SIZE_W-1:0]                    d_size,
  output logic     [`TL_SOURCE_W-1:0]                  d_source,
  output logic                                         d_denied,
  output logic     [`TL_DATA_W-1:0]                    d_data
);

  logic                     locked_q;
  logic [`TL_NUM_LINKS-1:0] sel_q;
  logic [`TL_NUM_LINKS-1:0] arb_grant;
  logic [tl_burst_w-1:0]    len_q;
  logic                     beat_last;
  logic                     beat_xfer;

  ////////////////////////////////////////////////////////////
  // Arbitration and lock
  ////////////////////////////////////////////////////////////

  tl_rr_arbiter #(
    .Width (`TL_NUM_LINKS)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .enable  (!locked_q),
    .request (dev_d_valid),
    .grant   (arb_grant)
  );

  assign beat_xfer = d_valid && d_ready;

  // Single-beat messages end while the counter is still zero
  assign beat_last = (len_q == '0) ? (d_size <= tl_non_burst_size || !d_opcode[0])
                                   : (len_q == tl_burst_w'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q <= 1'b0;
      sel_q    <= '0;
      len_q    <= '0;
    end else begin
      if (locked_q) begin
        if (beat_xfer && beat_last) begin
          locked_q <= 1'b0;
        end
      end else if (|arb_grant) begin
        locked_q <= 1'b1;
        sel_q    <= arb_grant;
      end
      // Count down the rest of a data burst
      if (beat_xfer) begin
        if (len_q == '0) begin
          if (d_opcode[0]) begin
            len_q <= tl_burst_len(d_size);
          end
        end else begin
          len_q <= len_q - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response multiplexer
  ////////////////////////////////////////////////////////////

  assign dev_d_ready = (locked_q && d_ready) ? sel_q : '0;

  always_comb begin
    d_valid  = 1'b0;
    d_opcode = tl_access_ack;
    d_size   = '0;
    d_source = '0;
    d_denied = 1'b0;
    d_data   = '0;
    for (int i = 0; i < `TL_NUM_LINKS; i++) begin
      if (locked_q && sel_q[i]) begin
        d_valid  = dev_d_valid[i];
        d_opcode = dev_d_opcode[i];
        d_size   = dev_d_size[i];
        d_source = dev_d_source[i];
        d_denied = dev_d_denied[i];
        d_data   = dev_d_data[i];
      end
    end
  end

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    locked_q |-> $onehot(sel_q));

  // A stalled beat must come back unchanged from the device
  a_d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid && !d_ready |=> d_valid && $stable({d_opcode, d_size, d_source, d_denied, d_data}));

endmodule

// ==== hw/tl_rr_arbiter.sv ====
`timescale 1ns/1ps

module tl_rr_arbiter #(
  parameter int unsigned Width = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             enable,
  input  logic [Width-1:0] request,
  output logic [Width-1:0] grant
);

  localparam int unsigned idx_w = (Width > 1) ? $clog2(Width) : 1;

  logic [idx_w-1:0] last_q;
  logic [idx_w-1:0] grant_idx;

  // Search starts one past the last winner
  always_comb begin
    int unsigned idx;
    logic        found;
    grant     = '0;
    grant_idx = last_q;
    found     = 1'b0;
    for (int unsigned k = 1; k <= Width; k++) begin
      idx = (32'(last_q) + k) % Width;
      if (!found && request[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = idx_w'(idx);
      end
    end
  end

  // Priority only moves on a grant that is taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= idx_w'(Width - 1);
    end else if (enable && |grant) begin
      last_q <= grant_idx;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(grant));

endmodule

// ==== hw/tl_socket_1n.sv ====
`timescale 1ns/1ps

module tl_socket_1n import tl_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,

  // Host side
  input  logic                                         a_valid,
  output logic                                         a_ready,
  input  tl_a_op_e                                     a_opcode,
  input  logic     [`TL_SIZE_W-1:0]                    a_size,
  input  logic     [`TL_SOURCE_W-1:0]                  a_source,
  input  logic     [`TL_ADDR_W-1:0]                    a_address,
  input  logic     [`TL_DATA_W/8-1:0]                  a_mask,
  input  logic     [`TL_DATA_W-1:0]                    a_data,
  output logic                                         d_valid,
  input  logic                                         d_ready,
  output tl_d_op_e                                     d_opcode,
  output logic     [`TL_SIZE_W-1:0]                    d_size,
  output logic     [`TL_SOURCE_W-1:0]                  d_source,
  output logic                                         d_denied,
  output logic     [`TL_DATA_W-1:0]                    d_data,

  // Device side
  output logic     [`TL_NUM_LINKS-1:0]                 dev_a_valid,
  input  logic     [`TL_NUM_LINKS-1:0]                 dev_a_ready,
  output tl_a_op_e                                     dev_a_opcode,
  output logic     [`TL_SIZE_W-1:0]                    dev_a_size,
  output logic     [`TL_SOURCE_W-1:0]                  dev_a_source,
  output logic     [`TL_ADDR_W-1:0]                    dev_a_address,
  output logic     [`TL_DATA_W/8-1:0]                  dev_a_mask,
  output logic     [`TL_DATA_W-1:0]                    dev_a_data,
  input  logic     [`TL_NUM_LINKS-1:0]                 dev_d_valid,
  output logic     [`TL_NUM_LINKS-1:0]                 dev_d_ready,
  input  tl_d_op_e [`TL_NUM_LINKS-1:0]                 dev_d_opcode,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_SIZE_W-1:0]   dev_d_size,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_SOURCE_W-1:0] dev_d_source,
  input  logic     [`TL_NUM_LINKS-1:0]                 dev_d_denied,
  input  logic     [`TL_NUM_LINKS-1:0][`TL_DATA_W-1:0]   dev_d_data
);

  localparam int unsigned link_w = (`TL_NUM_LINKS > 1) ? $clog2(`TL_NUM_LINKS) : 1;

  localparam logic [`TL_NUM_RANGES-1:0][`TL_ADDR_W-1:0] range_base = `TL_RANGE_BASE;
  localparam logic [`TL_NUM_RANGES-1:0][`TL_ADDR_W-1:0] range_mask = `TL_RANGE_MASK;
  localparam logic [`TL_NUM_RANGES-1:0][link_w-1:0]     range_link = `TL_RANGE_LINK;

  logic [link_w-1:0]        route_link;
  logic [`TL_NUM_LINKS-1:0] route_sel;

  ////////////////////////////////////////////////////////////
  // Request routing
  ////////////////////////////////////////////////////////////

  // Later ranges win on overlap, misses fall back to link 0
  always_comb begin
    route_link = '0;
    for (int r = 0; r < `TL_NUM_RANGES; r++) begin
      if ((a_address & ~range_mask[r]) == range_base[r]) begin
        route_link = range_link[r];
      end
    end
  end

  always_comb begin
    route_sel = '0;
    route_sel[route_link] = 1'b1;
  end

  assign dev_a_valid   = a_valid ? route_sel : '0;
  assign a_ready       = |(route_sel & dev_a_ready);

  assign dev_a_opcode  = a_opcode;
  assign dev_a_size    = a_size;
  assign dev_a_source  = a_source;
  assign dev_a_address = a_address;
  assign dev_a_mask    = a_mask;
  assign dev_a_data    = a_data;

  ////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////

  tl_resp_mux u_resp_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dev_d_valid  (dev_d_valid),
    .dev_d_ready  (dev_d_ready),
    .dev_d_opcode (dev_d_opcode),
    .dev_d_size   (dev_d_size),
    .dev_d_source (dev_d_source),
    .dev_d_denied (dev_d_denied),
    .dev_d_data   (dev_d_data),
    .d_valid      (d_valid),
    .d_ready      (d_ready),
    .d_opcode     (d_opcode),
    .d_size       (d_size),
    .d_source     (d_source),
    .d_denied     (d_denied),
    .d_data       (d_data)
  );

  a_one_link: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(dev_a_valid));

endmodule

// ==== hw/tl_xbar_top.sv ====
`timescale 1ns/1ps

module tl_xbar_top import tl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    a_valid,
  output logic                    a_ready,
  input  tl_a_op_e                a_opcode,
  input  logic [`TL_SIZE_W-1:0]   a_size,
  input  logic [`TL_SOURCE_W-1:0] a_source,
  input  logic [`TL_ADDR_W-1:0]   a_address,
  input  logic [`TL_DATA_W/8-1:0] a_mask,
  input  logic [`TL_DATA_W-1:0]   a_data,

  output logic                    d_valid,
  input  logic                    d_ready,
  output tl_d_op_e                d_opcode,
  output logic [`TL_SIZE_W-1:0]   d_size,
  output logic [`TL_SOURCE_W-1:0] d_source,
  output logic                    d_denied,
  output logic [`TL_DATA_W-1:0]   d_data
);

  logic     [`TL_NUM_LINKS-1:0]                   dev_a_valid;
  logic     [`TL_NUM_LINKS-1:0]                   dev_a_ready;
  tl_a_op_e                                       dev_a_opcode;
  logic     [`TL_SIZE_W-1:0]                      dev_a_size;
  logic     [`TL_SOURCE_W-1:0]                    dev_a_source;
  logic     [`TL_ADDR_W-1:0]                      dev_a_address;
  logic     [`TL_DATA_W/8-1:0]                    dev_a_mask;
  logic     [`TL_DATA_W-1:0]                      dev_a_data;
  logic     [`TL_NUM_LINKS-1:0]                   dev_d_valid;
  logic     [`TL_NUM_LINKS-1:0]                   dev_d_ready;
  tl_d_op_e [`TL_NUM_LINKS-1:0]                   dev_d_opcode;
  logic     [`TL_NUM_LINKS-1:0][`TL_SIZE_W-1:0]   dev_d_size;
  logic     [`TL_NUM_LINKS-1:0][`TL_SOURCE_W-1:0] dev_d_source;
  logic     [`TL_NUM_LINKS-1:0]                   dev_d_denied;
  logic     [`TL_NUM_LINKS-1:0][`TL_DATA_W-1:0]   dev_d_data;

  tl_socket_1n u_socket (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .a_valid       (a_valid),
    .a_ready       (a_ready),
    .a_opcode      (a_opcode),
    .a_size        (a_size),
    .a_source      (a_source),
    .a_address     (a_address),
    .a_mask        (a_mask),
    .a_data        (a_data),
    .d_valid       (d_valid),
    .d_ready       (d_ready),
    .d_opcode      (d_opcode),
    .d_size        (d_size),
    .d_source      (d_source),
    .d_denied      (d_denied),
    .d_data        (d_data),
    .dev_a_valid   (dev_a_valid),
    .dev_a_ready   (dev_a_ready),
    .dev_a_opcode  (dev_a_opcode),
    .dev_a_size    (dev_a_size),
    .dev_a_source  (dev_a_source),
    .dev_a_address (dev_a_address),
    .dev_a_mask    (dev_a_mask),
    .dev_a_data    (dev_a_data),
    .dev_d_valid   (dev_d_valid),
    .dev_d_ready   (dev_d_ready),
    .dev_d_opcode  (dev_d_opcode),
    .dev_d_size    (dev_d_size),
    .dev_d_source  (dev_d_source),
    .dev_d_denied  (dev_d_denied),
    .dev_d_data    (dev_d_data)
  );

  // Link 0, also the default for unmatched addresses
  tl_ram_device u_dev0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid   (dev_a_valid[0]),
    .a_ready   (dev_a_ready[0]),
    .a_opcode  (dev_a_opcode),
    .a_size    (dev_a_size),
    .a_source  (dev_a_source),
    .a_address (dev_a_address),
    .a_mask    (dev_a_mask),
    .a_data    (dev_a_data),
    .d_valid   (dev_d_valid[0]),
    .d_ready   (dev_d_ready[0]),
    .d_opcode  (dev_d_opcode[0]),
    .d_size    (dev_d_size[0]),
    .d_source  (dev_d_source[0]),
    .d_denied  (dev_d_denied[0]),
    .d_data    (dev_d_data[0])
  );

  // Link 1, the routed range
  tl_ram_device u_dev1 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid   (dev_a_valid[1]),
    .a_ready   (dev_a_ready[1]),
    .a_opcode  (dev_a_opcode),
    .a_size    (dev_a_size),
    .a_source  (dev_a_source),
    .a_address (dev_a_address),
    .a_mask    (dev_a_mask),
    .a_data    (dev_a_data),
    .d_valid   (dev_d_valid[1]),
    .d_ready   (dev_d_ready[1]),
    .d_opcode  (dev_d_opcode[1]),
    .d_size    (dev_d_size[1]),
    .d_source  (dev_d_source[1]),
    .d_denied  (dev_d_denied[1]),
    .d_data    (dev_d_data[1])
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_top -o tb_top_sim
./obj_dir/tb_top_sim | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished without errors"

// ==== tb/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam int n_src     = 1 << `TL_SOURCE_W;
localparam int max_beats = 1 << (`TL_MAX_SIZE - 3);

// Reference memory, one word array per device link
logic [`TL_DATA_W-1:0] ref_mem [`TL_NUM_LINKS][`TL_RAM_WORDS];

// Expected message for each source in flight
tl_d_op_e              exp_op    [n_src];
logic                  exp_den   [n_src];
logic [`TL_SIZE_W-1:0] exp_size  [n_src];
int                    exp_beats [n_src];
logic [`TL_DATA_W-1:0] exp_data  [n_src][max_beats];

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Single range, misses go to link 0
function automatic int ref_link(input logic [`TL_ADDR_W-1:0] addr);
  if ((addr & ~`TL_RANGE_MASK) == `TL_RANGE_BASE) begin
    return `TL_RANGE_LINK;
  end
  return 0;
endfunction

// Word index from the address, one word per 8 bytes
function automatic int ref_index(input logic [`TL_ADDR_W-1:0] addr);
  return (int'(addr) / 8) % `TL_RAM_WORDS;
endfunction

function automatic int ref_beats(input logic [`TL_SIZE_W-1:0] size);
  if (int'(size) <= 3) begin
    return 1;
  end
  return 1 << (int'(size) - 3);
endfunction

function automatic void predict_resp(input logic [`TL_SOURCE_W-1:0] src, input tl_a_op_e op,
                                     input logic [`TL_SIZE_W-1:0] size,
                                     input logic [`TL_ADDR_W-1:0] addr);
  int link;
  int idx;
  link = ref_link(addr);
  idx  = ref_index(addr);
  // Every beat of the response carries the request size
  exp_size[src] = size;
  if (op == tl_get) begin
    exp_op[src]    = tl_access_ack_data;
    exp_den[src]   = 1'b0;
    exp_beats[src] = ref_beats(size);
    // Burst words run on from the start index and wrap
    for (int k = 0; k < exp_beats[src]; k++) begin
      exp_data[src][k] = ref_mem[link][(idx + k) % `TL_RAM_WORDS];
    end
  end else begin
    exp_op[src]      = tl_access_ack;
    exp_den[src]     = (int'(size) > 3);
    exp_beats[src]   = 1;
    exp_data[src][0] = '0;
  end
endfunction

// Masked byte write, only for single-beat Puts
function automatic void ref_write(input tl_a_op_e op, input logic [`TL_SIZE_W-1:0] size,
                                  input logic [`TL_ADDR_W-1:0] addr,
                                  input logic [`TL_DATA_W/8-1:0] mask,
                                  input logic [`TL_DATA_W-1:0] data);
  int link;
  int idx;
  link = ref_link(addr);
  idx  = ref_index(addr);
  if (op == tl_put_full_data && int'(size) <= 3) begin
    for (int b = 0; b < `TL_DATA_W / 8; b++) begin
      if (mask[b]) begin
        ref_mem[link][idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  end
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_opcode(input string name, input tl_d_op_e exp, input tl_d_op_e got);
  chk_cnt++;
  if (got !== exp) begin
    $display("ERR [%0t] %s: expected %0h, got %0h", $time, name, exp, got);
    err_cnt++;
  end
endtask

task automatic check_data(input string name, input logic [`TL_DATA_W-1:0] exp,
                          input logic [`TL_DATA_W-1:0] got);
  chk_cnt++;
  if (got !== exp) begin
    $display("ERR [%0t] %s: expected %016h, got %016h", $time, name, exp, got);
    err_cnt++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
  chk_cnt++;
  if (got !== exp) begin
    $display("ERR [%0t] %s: expected %b, got %b", $time, name, exp, got);
    err_cnt++;
  end
endtask

task automatic check_source(input string name, input logic [`TL_SOURCE_W-1:0] exp,
                            input logic [`TL_SOURCE_W-1:0] got);
  chk_cnt++;
  if (got !== exp) begin
    $display("ERR [%0t] %s: expected %0d, got %0d", $time, name, exp, got);
    err_cnt++;
  end
endtask

task automatic check_size(input string name, input logic [`TL_SIZE_W-1:0] exp,
                          input logic [`TL_SIZE_W-1:0] got);
  chk_cnt++;
  if (got !== exp) begin
    $display("ERR [%0t] %s: expected %0d, got %0d", $time, name, exp, got);
    err_cnt++;
  end
endtask

`endif

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`include "tl_cfg.svh"

module tb_top import tl_pkg::*; ();

  localparam int timeout_cycles = 400;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    a_valid;
  logic                    a_ready;
  tl_a_op_e                a_opcode;
  logic [`TL_SIZE_W-1:0]   a_size;
  logic [`TL_SOURCE_W-1:0] a_source;
  logic [`TL_ADDR_W-1:0]   a_address;
  logic [`TL_DATA_W/8-1:0] a_mask;
  logic [`TL_DATA_W-1:0]   a_data;
  logic                    d_valid;
  logic                    d_ready;
  tl_d_op_e                d_opcode;
  logic [`TL_SIZE_W-1:0]   d_size;
  logic [`TL_SOURCE_W-1:0] d_source;
  logic                    d_denied;
  logic [`TL_DATA_W-1:0]   d_data;

  integer                  seed;
  logic                    rand_ready;
  int                      err_cnt;
  int                      chk_cnt;
  int                      msg_cnt;
  int                      test_cnt;
  int                      fail_cnt;

  // Sources waiting for their first response beat
  logic [`TL_SOURCE_W-1:0] exp_q [$];
  logic                    in_msg;
  logic [`TL_SOURCE_W-1:0] cur_src;
  int                      beat_idx;
  logic [`TL_SOURCE_W-1:0] next_src;

  `include "tb_ref.svh"

  tl_xbar_top DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_opcode  (a_opcode),
    .a_size    (a_size),
    .a_source  (a_source),
    .a_address (a_address),
    .a_mask    (a_mask),
    .a_data    (a_data),
    .d_valid   (d_valid),
    .d_ready   (d_ready),
    .d_opcode  (d_opcode),
    .d_size    (d_size),
    .d_source  (d_source),
    .d_denied  (d_denied),
    .d_data    (d_data)
  );

  always #4 clk_i = ~clk_i;

  // Host back-pressure, ready about three cycles in four when random
  always @(posedge clk_i) begin
    #1;
    if (rand_ready) begin
      d_ready = (($random(seed) & 3) != 0);
    end else begin
      d_ready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    int   pos;
    logic found;
    if (rst_ni) begin
      if (in_msg && !d_valid) begin
        $display("[%0t] d_valid fell inside the message of source %0d", $time, cur_src);
        err_cnt++;
        in_msg = 1'b0;
      end
      if (d_valid && d_ready) begin
        found = 1'b0;
        pos   = 0;
        if (!in_msg) begin
          // First beat, look the source up among the open requests
          foreach (exp_q[i]) begin
            if (!found && exp_q[i] == d_source) begin
              found = 1'b1;
              pos   = i;
            end
          end
          if (found) begin
            exp_q.delete(pos);
            in_msg   = 1'b1;
            cur_src  = d_source;
            beat_idx = 0;
          end else begin
            $display("[%0t] response with source %0d matches no request", $time, d_source);
            err_cnt++;
          end
        end else begin
          check_source("d_source", cur_src, d_source);
        end
        if (in_msg) begin
          check_opcode("d_opcode", exp_op[cur_src], d_opcode);
          check_flag("d_denied", exp_den[cur_src], d_denied);
          check_size("d_size", exp_size[cur_src], d_size);
          if (exp_op[cur_src] == tl_access_ack_data) begin
            check_data("d_data", exp_data[cur_src][beat_idx], d_data);
          end
          beat_idx++;
          if (beat_idx >= exp_beats[cur_src]) begin
            in_msg = 1'b0;
            msg_cnt++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Driver helpers
  ////////////////////////////////////////////////////////////

  function automatic logic src_busy(input logic [`TL_SOURCE_W-1:0] src);
    logic busy;
    busy = in_msg && (cur_src == src);
    foreach (exp_q[i]) begin
      if (exp_q[i] == src) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  // Word pattern built from the whole address
  function automatic logic [`TL_DATA_W-1:0] fill_word(input logic [`TL_ADDR_W-1:0] addr);
    return {addr, ~addr, addr ^ 16'h5a5a, addr + 16'h0101};
  endfunction

  // Called and returns one time unit after a rising edge
  task automatic issue_req(input tl_a_op_e op, input logic [`TL_SIZE_W-1:0] size,
                           input logic [`TL_ADDR_W-1:0] addr,
                           input logic [`TL_DATA_W/8-1:0] mask,
                           input logic [`TL_DATA_W-1:0] data);
    logic [`TL_SOURCE_W-1:0] src;
    int                      waited;
    logic                    taken;
    src      = next_src;
    next_src = next_src + 1'b1;
    waited   = 0;
    while (src_busy(src) && waited < timeout_cycles) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (src_busy(src)) begin
      $display("[%0t] source %0d stayed in use too long", $time, src);
      err_cnt++;
    end
    predict_resp(src, op, size, addr);
    ref_write(op, size, addr, mask, data);
    exp_q.push_back(src);
    a_valid   = 1'b1;
    a_opcode  = op;
    a_size    = size;
    a_source  = src;
    a_address = addr;
    a_mask    = mask;
    a_data    = data;
    taken     = 1'b0;
    waited    = 0;
    while (!taken && waited < timeout_cycles) begin
      @(negedge clk_i);
      if (a_ready) begin
        taken = 1'b1;
      end else begin
        waited++;
      end
      @(posedge clk_i);
    end
    #1;
    a_valid = 1'b0;
    if (!taken) begin
      $display("[%0t] request to %04h was never accepted", $time, addr);
      err_cnt++;
    end
  endtask

  task automatic wait_idle(input string name);
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || in_msg) && waited < timeout_cycles) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0 || in_msg) begin
      $display("[%0t] %s: responses still missing after the timeout", $time, name);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [`TL_ADDR_W-1:0] base;
    int                    errs;
    seed       = 32'h6fe2;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    a_valid    = 1'b0;
    a_opcode   = tl_get;
    a_size     = '0;
    a_source   = '0;
    a_address  = '0;
    a_mask     = '0;
    a_data     = '0;
    d_ready    = 1'b0;
    rand_ready = 1'b0;
    in_msg     = 1'b0;
    cur_src    = '0;
    beat_idx   = 0;
    next_src   = '0;
    err_cnt    = 0;
    chk_cnt    = 0;
    msg_cnt    = 0;
    test_cnt   = 0;
    fail_cnt   = 0;
    for (int l = 0; l < `TL_NUM_LINKS; l++) begin
      for (int w = 0; w < `TL_RAM_WORDS; w++) begin
        ref_mem[l][w] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Two Puts merge into one word, then read back on each link
    errs = err_cnt;
    check_flag("d_valid", 1'b0, d_valid);
    check_flag("a_ready", 1'b1, a_ready);
    for (int l = 0; l < `TL_NUM_LINKS; l++) begin
      base = (l == `TL_RANGE_LINK) ? `TL_RANGE_BASE : 16'h0000;
      issue_req(tl_put_full_data, 3'd3, base + 16'h0018, 8'hFF, fill_word(base + 16'h0018));
      issue_req(tl_put_full_data, 3'd3, base + 16'h0018, 8'h3C, ~fill_word(base));
      issue_req(tl_get, 3'd3, base + 16'h0018, '0, '0);
    end
    wait_idle("put_get");
    report_test("put_get", errs);

    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      base = 16'h1040 + 16'(8 * k);
      issue_req(tl_put_full_data, 3'd3, base, 8'hFF, fill_word(base));
    end
    issue_req(tl_get, 3'd5, 16'h1040, '0, '0);
    wait_idle("get_burst");
    report_test("get_burst", errs);

    // Bursts on both links under back-pressure, one of them wrapping
    errs       = err_cnt;
    rand_ready = 1'b1;
    for (int k = 0; k < 4; k++) begin
      base = 16'h01E0 + 16'(8 * k);
      issue_req(tl_put_full_data, 3'd3, base, 8'hFF, fill_word(base));
    end
    for (int i = 0; i < 3; i++) begin
      issue_req(tl_get, 3'd5, 16'h01F0, '0, '0);
      issue_req(tl_get, 3'd5, 16'h1040, '0, '0);
      issue_req(tl_get, 3'd4, 16'h01E0 + 16'(16 * i), '0, '0);
      issue_req(tl_get, 3'd3, 16'h1058, '0, '0);
    end
    wait_idle("interleave");
    rand_ready = 1'b0;
    report_test("interleave", errs);

    errs = err_cnt;
    issue_req(tl_put_full_data, 3'd3, 16'h2008, 8'hFF, fill_word(16'h2008));
    issue_req(tl_get, 3'd3, 16'h0008, '0, '0);
    issue_req(tl_get, 3'd3, 16'h2008, '0, '0);
    issue_req(tl_get, 3'd3, 16'h1008, '0, '0);
    wait_idle("default_route");
    report_test("default_route", errs);

    errs = err_cnt;
    issue_req(tl_put_full_data, 3'd3, 16'h1000, 8'hFF, fill_word(16'h1000));
    issue_req(tl_put_full_data, 3'd4, 16'h1000, 8'hFF, ~fill_word(16'h1000));
    issue_req(tl_get, 3'd3, 16'h1000, '0, '0);
    wait_idle("denied_put");
    report_test("denied_put", errs);

    $display("tests run: %0d, failing: %0d, checks: %0d, errors: %0d, messages: %0d",
             test_cnt, fail_cnt, chk_cnt, err_cnt, msg_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
